/* Bender.yml */
package:
  name: timer_subsys

sources:
  - files:
      - logic/timer_pkg.sv
      - logic/apb_if.sv
      - logic/apb_demux.sv
      - logic/periph_timer.sv
      - logic/timer_subsys.sv
  - target: test
    files:
      - verification/timer_subsys_checker.sv
      - verification/tb_timer_subsys.sv

/* logic/apb_demux.sv */
`default_nettype none

module apb_demux (
    input  logic clk,
    input  logic rst,
    apb_if.slave  host,
    apb_if.master timers [timer_pkg::NUM_TIMERS]
);
    import timer_pkg::*;

    // Timer number field above the per-timer window
    logic [ADDR_WIDTH-TIMER_SPAN_BITS-1:0] tnum;
    logic                                  hit;

    // Responses gathered from the timer slaves
    logic                  t_pready  [NUM_TIMERS];
    logic [DATA_WIDTH-1:0] t_prdata  [NUM_TIMERS];
    logic                  t_pslverr [NUM_TIMERS];

    // Local responder for unmapped addresses
    logic err_ready;

    assign tnum = host.paddr[ADDR_WIDTH-1:TIMER_SPAN_BITS];
    assign hit  = (tnum < NUM_TIMERS);

    for (genvar g = 0; g < NUM_TIMERS; g++) begin : g_fanout
        assign timers[g].paddr   = host.paddr;
        assign timers[g].psel    = host.psel && (tnum == g); // Only the addressed timer
        assign timers[g].penable = host.penable;
        assign timers[g].pwrite  = host.pwrite;
        assign timers[g].pwdata  = host.pwdata;
        assign timers[g].pstrb   = host.pstrb;

        assign t_pready[g]  = timers[g].pready;
        assign t_prdata[g]  = timers[g].prdata;
        assign t_pslverr[g] = timers[g].pslverr;
    end

    // Same one-cycle timing as a timer slave
    always_ff @(posedge clk) begin
        if (rst) begin
            err_ready <= 1'b0;
        end else if (host.psel && !hit && !err_ready) begin
            err_ready <= 1'b1;
        end else if (err_ready && host.psel && host.penable) begin
            err_ready <= 1'b0; // Transfer done
        end
    end

    always_comb begin
        // Falls back to the error responder when no timer matches
        host.pready  = err_ready;
        host.pslverr = err_ready;
        host.prdata  = '0;
        for (int i = 0; i < NUM_TIMERS; i++) begin
            if (tnum == i) begin
                host.pready  = t_pready[i];
                host.prdata  = t_prdata[i];
                host.pslverr = t_pslverr[i];
            end
        end
    end

endmodule

`default_nettype wire

/* logic/apb_if.sv */
`default_nettype none

interface apb_if;
    import timer_pkg::*;

    // Request, master to slave
    logic [ADDR_WIDTH-1:0] paddr;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [DATA_WIDTH-1:0] pwdata;
    logic [STRB_WIDTH-1:0] pstrb;

    // Response, slave to master
    logic                  pready;
    logic [DATA_WIDTH-1:0] prdata;
    logic                  pslverr;

    modport master (
        output paddr, psel, penable, pwrite, pwdata, pstrb,
        input  pready, prdata, pslverr
    );

    modport slave (
        input  paddr, psel, penable, pwrite, pwdata, pstrb,
        output pready, prdata, pslverr
    );

endinterface

`default_nettype wire

/* logic/periph_timer.sv */
`default_nettype none

module periph_timer (
    input  logic clk,
    input  logic rst,

    input  logic pause_req,
    output logic pause_ack,

    apb_if.slave apb,

    output logic irq
);
    import timer_pkg::*;

    // Register file
    logic [DATA_WIDTH-1:0] control;
    logic [DATA_WIDTH-1:0] prescaler;
    logic [DATA_WIDTH-1:0] value;
    logic [DATA_WIDTH-1:0] auto_reload;
    logic [DATA_WIDTH-1:0] events;
    logic [DATA_WIDTH-1:0] interrupt_enable;

    logic [DATA_WIDTH-1:0] clk_count; // Prescale counter

    // Access decode
    logic [TIMER_SPAN_BITS-1:$clog2(STRB_WIDTH)] index;
    logic [DATA_WIDTH-1:0] mask;
    logic [DATA_WIDTH-1:0] rd_data;
    logic                  reg_hit;

    logic paused;
    logic access;
    logic complete;
    logic wr;
    logic enable;

    function automatic logic [DATA_WIDTH-1:0] merge(
        input logic [DATA_WIDTH-1:0] old_val,
        input logic [DATA_WIDTH-1:0] new_val,
        input logic [DATA_WIDTH-1:0] lane_mask
    );
        return (new_val & lane_mask) | (old_val & ~lane_mask);
    endfunction

    always_comb begin
        index = apb.paddr[TIMER_SPAN_BITS-1:$clog2(STRB_WIDTH)];

        // Byte strobes expanded to a bit mask
        for (int i = 0; i < STRB_WIDTH; i++) begin
            mask[i*8 +: 8] = {8{apb.pstrb[i]}};
        end

        reg_hit = 1'b1;
        rd_data = '0;
        case (index)
            REG_CR:  rd_data = control;
            REG_PR:  rd_data = prescaler;
            REG_VR:  rd_data = value;
            REG_ARR: rd_data = auto_reload;
            REG_ER:  rd_data = events;
            REG_IER: rd_data = interrupt_enable;
            default: reg_hit = 1'b0; // Hole in the map
        endcase
    end

    assign paused   = pause_req && pause_ack;
    assign access   = !pause_req && apb.psel && !apb.pready;          // Pending and not yet answered
    assign complete = !pause_ack && apb.psel && apb.penable && apb.pready;
    assign wr       = access && apb.pwrite;
    assign enable   = control[CR_ENABLE];

    assign irq = enable && events[ER_AUTO_RELOAD] && interrupt_enable[IER_AUTO_RELOAD]
                 && !pause_ack;

    // APB handshake and pause acknowledge
    always_ff @(posedge clk) begin
        if (rst) begin
            apb.pready  <= 1'b0;
            apb.pslverr <= 1'b0;
            apb.prdata  <= '0;
            pause_ack   <= 1'b0;
        end else if (!paused) begin
            if (access) begin
                apb.pready  <= 1'b1;
                apb.pslverr <= !reg_hit;
                apb.prdata  <= apb.pwrite ? '0 : rd_data;
            end else if (complete) begin
                apb.pready  <= 1'b0;
                apb.pslverr <= 1'b0;
                apb.prdata  <= '0;
            end else if (pause_req && !pause_ack) begin
                // Enter pause so every access now ends in an error
                pause_ack   <= 1'b1;
                apb.pready  <= 1'b1;
                apb.pslverr <= 1'b1;
                apb.prdata  <= '0;
            end else if (!pause_req && pause_ack) begin
                pause_ack   <= 1'b0; // Resume
                apb.pready  <= 1'b0;
                apb.pslverr <= 1'b0;
                apb.prdata  <= '0;
            end
        end
    end

    // Register writes and counting freeze while paused
    always_ff @(posedge clk) begin
        if (rst) begin
            control          <= '0;
            prescaler        <= '0;
            value            <= '0;
            auto_reload      <= '0;
            events           <= '0;
            interrupt_enable <= '0;
            clk_count        <= '0;
        end else if (!paused) begin
            if (wr) begin
                case (index)
                    REG_CR:  control          <= merge(control, apb.pwdata, mask);
                    REG_PR:  prescaler        <= merge(prescaler, apb.pwdata, mask);
                    REG_VR:  value            <= merge(value, apb.pwdata, mask);
                    REG_ARR: auto_reload      <= merge(auto_reload, apb.pwdata, mask);
                    REG_ER:  events           <= events & ~(apb.pwdata & mask); // W1C
                    REG_IER: interrupt_enable <= merge(interrupt_enable, apb.pwdata, mask);
                    default: ;
                endcase
            end

            // Counter updates win over a same-cycle register write
            if (enable) begin
                if (clk_count < prescaler) begin
                    clk_count <= clk_count + 1'b1;
                end else begin
                    clk_count <= '0;
                    if (value == auto_reload) begin
                        events[ER_AUTO_RELOAD] <= 1'b1;
                        value                  <= '0; // Wrap
                    end else begin
                        value <= value + 1'b1;
                    end
                end
            end else begin
                clk_count <= '0;
                events    <= '0;
            end
        end
    end

endmodule

`default_nettype wire

/* logic/timer_pkg.sv */
`default_nettype none

package timer_pkg;

    // APB bus widths
    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;
    localparam int STRB_WIDTH = DATA_WIDTH / 8;

    // Cluster layout
    localparam int NUM_TIMERS      = 2;
    localparam int TIMER_SPAN_BITS = 12; // 4 KiB window per timer

    // Register word indices
    localparam int REG_CR  = 0; // Control
    localparam int REG_PR  = 1; // Prescaler
    localparam int REG_VR  = 2; // Value
    localparam int REG_ARR = 3; // Auto-reload
    localparam int REG_ER  = 4; // Events, write one to clear
    localparam int REG_IER = 5; // Interrupt enable

    // Bit positions
    localparam int CR_ENABLE       = 0;
    localparam int ER_AUTO_RELOAD  = 0;
    localparam int IER_AUTO_RELOAD = 0;

endpackage

`default_nettype wire

/* logic/timer_subsys.sv */
`default_nettype none

module timer_subsys (
    input  logic clk,
    input  logic rst,

    // APB slave port
    input  logic [timer_pkg::ADDR_WIDTH-1:0] paddr,
    input  logic                             psel,
    input  logic                             penable,
    input  logic                             pwrite,
    input  logic [timer_pkg::DATA_WIDTH-1:0] pwdata,
    input  logic [timer_pkg::STRB_WIDTH-1:0] pstrb,
    output logic                             pready,
    output logic [timer_pkg::DATA_WIDTH-1:0] prdata,
    output logic                             pslverr,

    // Shared pause request, one ack per timer
    input  logic                             pause_req,
    output logic [timer_pkg::NUM_TIMERS-1:0] pause_ack,

    output logic [timer_pkg::NUM_TIMERS-1:0] irq
);
    import timer_pkg::*;

    apb_if host_bus ();
    apb_if timer_bus [NUM_TIMERS] ();

    // Plain ports onto the host bus
    assign host_bus.paddr   = paddr;
    assign host_bus.psel    = psel;
    assign host_bus.penable = penable;
    assign host_bus.pwrite  = pwrite;
    assign host_bus.pwdata  = pwdata;
    assign host_bus.pstrb   = pstrb;

    assign pready  = host_bus.pready;
    assign prdata  = host_bus.prdata;
    assign pslverr = host_bus.pslverr;

    // Address map, one 4 KiB window per timer
    apb_demux u_demux (
        .clk    (clk),
        .rst    (rst),
        .host   (host_bus),
        .timers (timer_bus)
    );

    for (genvar i = 0; i < NUM_TIMERS; i++) begin : g_timer
        periph_timer u_timer (
            .clk       (clk),
            .rst       (rst),
            .pause_req (pause_req),      // Same request for every timer
            .pause_ack (pause_ack[i]),
            .apb       (timer_bus[i]),
            .irq       (irq[i])
        );
    end

endmodule

`default_nettype wire

/* sim.f */
logic/timer_pkg.sv
logic/apb_if.sv
logic/apb_demux.sv
logic/periph_timer.sv
logic/timer_subsys.sv
verification/timer_subsys_checker.sv
verification/tb_timer_subsys.sv

/* verification/tb_timer_subsys.sv */
`default_nettype none

module tb_timer_subsys;
    import timer_pkg::*;

    localparam int          WAIT_LIMIT = 16; // Cycles allowed for any handshake
    localparam logic [31:0] LFSR_SEED  = 32'h5328af66;

    logic                  clk;
    logic                  rst;
    logic [ADDR_WIDTH-1:0] paddr;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [DATA_WIDTH-1:0] pwdata;
    logic [STRB_WIDTH-1:0] pstrb;
    logic                  pready;
    logic [DATA_WIDTH-1:0] prdata;
    logic                  pslverr;
    logic                  pause_req;
    logic [NUM_TIMERS-1:0] pause_ack;
    logic [NUM_TIMERS-1:0] irq;

    logic [31:0] lfsr_state;
    string       cur_test;
    int          errors;       // Within the running test
    int          total_errors;
    int          run_tests;
    int          failed_tests;

    timer_subsys dut_i (
        .clk       (clk),
        .rst       (rst),
        .paddr     (paddr),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .pwdata    (pwdata),
        .pstrb     (pstrb),
        .pready    (pready),
        .prdata    (prdata),
        .pslverr   (pslverr),
        .pause_req (pause_req),
        .pause_ack (pause_ack),
        .irq       (irq)
    );

    always #10 clk = ~clk;

    // Galois form, taps x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
        return v;
    endfunction

    function automatic logic [ADDR_WIDTH-1:0] reg_addr(input int t, input int idx);
        return (ADDR_WIDTH'(t) << TIMER_SPAN_BITS) | (ADDR_WIDTH'(idx) << $clog2(STRB_WIDTH));
    endfunction

    task automatic check_value(input string what, input logic [DATA_WIDTH-1:0] expected,
                               input logic [DATA_WIDTH-1:0] actual);
        assert (actual === expected) else begin
            $display("[ERROR] %s, %s: expected %h, actual %h", cur_test, what, expected, actual);
            errors++;
        end
    endtask

    task automatic check_cond(input bit ok, input string msg);
        assert (ok) else begin
            $display("%s: %s", cur_test, msg);
            errors++;
        end
    endtask

    // One APB transfer, setup then access until pready
    task automatic apb_transfer(input logic [ADDR_WIDTH-1:0] addr, input logic wr,
                                input logic [DATA_WIDTH-1:0] wdata,
                                input logic [STRB_WIDTH-1:0] strb,
                                output logic [DATA_WIDTH-1:0] rdata, output logic err);
        int waited;
        @(negedge clk);
        paddr   = addr;
        pwrite  = wr;
        pwdata  = wdata;
        pstrb   = wr ? strb : '0;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge clk);
        penable = 1'b1;
        waited  = 0;
        while (!pready && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        check_cond(pready, $sformatf("no pready for address %h within %0d cycles", addr, waited));
        rdata = pready ? prdata : '0;
        err   = pready ? pslverr : 1'b1;
        @(negedge clk); // Completion edge has passed
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input logic [ADDR_WIDTH-1:0] addr, input logic [DATA_WIDTH-1:0] data,
                             input logic [STRB_WIDTH-1:0] strb, output logic err);
        logic [DATA_WIDTH-1:0] unused;
        apb_transfer(addr, 1'b1, data, strb, unused, err);
    endtask

    task automatic apb_read(input logic [ADDR_WIDTH-1:0] addr, output logic [DATA_WIDTH-1:0] data,
                            output logic err);
        apb_transfer(addr, 1'b0, '0, '0, data, err);
    endtask

    task automatic write_reg(input int t, input int idx, input logic [DATA_WIDTH-1:0] data);
        logic err;
        apb_write(reg_addr(t, idx), data, '1, err);
        check_value("write pslverr", 0, err);
    endtask

    task automatic read_reg(input int t, input int idx, output logic [DATA_WIDTH-1:0] data);
        logic err;
        apb_read(reg_addr(t, idx), data, err);
        check_value("read pslverr", 0, err);
    endtask

    // Polls value and event until the auto-reload event shows up
    task automatic wait_for_event(input int t, input logic [DATA_WIDTH-1:0] reload, input int polls);
        logic [DATA_WIDTH-1:0] v;
        logic [DATA_WIDTH-1:0] ev;
        int                    n;
        n  = 0;
        ev = '0;
        while (!ev[ER_AUTO_RELOAD] && n < polls) begin
            read_reg(t, REG_VR, v);
            check_cond(v <= reload, $sformatf("value %0d above auto-reload %0d", v, reload));
            read_reg(t, REG_ER, ev);
            n++;
        end
        check_cond(ev[ER_AUTO_RELOAD], $sformatf("timer %0d event not set after %0d polls", t, n));
    endtask

    task automatic finish_test();
        run_tests++;
        total_errors += errors;
        if (errors == 0) begin
            $display("%s: ok", cur_test);
        end else begin
            failed_tests++;
            $display("%s: %0d errors", cur_test, errors);
        end
    endtask

    task automatic reset_and_strobe_test();
        logic [DATA_WIDTH-1:0] d;
        logic [DATA_WIDTH-1:0] base;
        logic [DATA_WIDTH-1:0] upd;
        logic [DATA_WIDTH-1:0] expected;
        logic [STRB_WIDTH-1:0] strb;
        logic                  err;
        cur_test = "reset_and_strobes";
        errors   = 0;
        for (int t = 0; t < NUM_TIMERS; t++) begin
            for (int idx = REG_CR; idx <= REG_IER; idx++) begin
                read_reg(t, idx, d);
                check_value($sformatf("timer %0d reg %0d after reset", t, idx), 0, d);
            end
        end
        for (int t = 0; t < NUM_TIMERS; t++) begin
            for (int idx = REG_PR; idx <= REG_ARR; idx += REG_ARR - REG_PR) begin
                base = rand_bits(DATA_WIDTH);
                upd  = rand_bits(DATA_WIDTH);
                strb = STRB_WIDTH'(rand_bits(STRB_WIDTH));
                write_reg(t, idx, base);
                apb_write(reg_addr(t, idx), upd, strb, err);
                check_value("strobed write pslverr", 0, err);
                for (int b = 0; b < STRB_WIDTH; b++) begin
                    expected[b*8 +: 8] = strb[b] ? upd[b*8 +: 8] : base[b*8 +: 8];
                end
                read_reg(t, idx, d);
                check_value($sformatf("timer %0d reg %0d strobe %b", t, idx, strb), expected, d);
            end
        end
        finish_test();
    endtask

    task automatic error_response_test();
        logic [DATA_WIDTH-1:0] d;
        logic                  err;
        cur_test = "error_responses";
        errors   = 0;
        for (int t = 0; t < NUM_TIMERS; t++) begin
            apb_read(reg_addr(t, REG_IER + 1), d, err);
            check_value($sformatf("timer %0d index 6 read pslverr", t), 1, err);
            apb_write(reg_addr(t, REG_IER + 1), rand_bits(DATA_WIDTH), '1, err);
            check_value($sformatf("timer %0d index 6 write pslverr", t), 1, err);
            read_reg(t, REG_CR, d); // Valid index, no error
        end
        // Beyond the last timer window
        apb_read(reg_addr(NUM_TIMERS, REG_CR), d, err);
        check_value("unmapped read pslverr", 1, err);
        check_value("unmapped read prdata", 0, d);
        apb_write(reg_addr(NUM_TIMERS, REG_PR), rand_bits(DATA_WIDTH), '1, err);
        check_value("unmapped write pslverr", 1, err);
        finish_test();
    endtask

    task automatic counting_test();
        logic [DATA_WIDTH-1:0] d;
        cur_test = "counting";
        errors   = 0;
        // Prescaler 3, reload 5, period of 24 cycles
        write_reg(0, REG_PR, 3);
        write_reg(0, REG_ARR, 5);
        write_reg(0, REG_VR, 0);
        write_reg(0, REG_IER, 1 << IER_AUTO_RELOAD);
        write_reg(0, REG_CR, 1 << CR_ENABLE);
        wait_for_event(0, 5, 4 * 24);
        check_value("irq with event pending", 'h1, irq);
        write_reg(0, REG_ER, 1 << ER_AUTO_RELOAD);
        check_value("irq after event clear", 'h0, irq);
        read_reg(0, REG_ER, d);
        check_value("event after clear", 0, d);
        wait_for_event(0, 5, 4 * 24);
        write_reg(0, REG_CR, 0);
        read_reg(0, REG_ER, d);
        check_value("event after disable", 0, d);
        check_value("irq after disable", 'h0, irq);
        finish_test();
    endtask

    task automatic independence_test();
        logic [DATA_WIDTH-1:0] snap [REG_IER+1];
        logic [DATA_WIDTH-1:0] d;
        cur_test = "independence";
        errors   = 0;
        for (int idx = REG_CR; idx <= REG_IER; idx++) begin
            read_reg(0, idx, snap[idx]);
        end
        write_reg(1, REG_PR, 1);
        write_reg(1, REG_ARR, 3);
        write_reg(1, REG_VR, 0);
        write_reg(1, REG_IER, 1 << IER_AUTO_RELOAD);
        write_reg(1, REG_CR, 1 << CR_ENABLE);
        wait_for_event(1, 3, 4 * 8);
        check_value("irq with timer 1 event", 'h2, irq);
        for (int idx = REG_CR; idx <= REG_IER; idx++) begin
            read_reg(0, idx, d);
            check_value($sformatf("timer 0 reg %0d", idx), snap[idx], d);
        end
        finish_test();
    endtask

    task automatic pause_test();
        logic [DATA_WIDTH-1:0] d;
        logic                  err;
        int                    waited;
        cur_test = "pause";
        errors   = 0;
        check_value("irq before pause", 'h2, irq); // Timer 1 event still pending
        @(negedge clk);
        pause_req = 1'b1;
        waited    = 0;
        while (pause_ack != '1 && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        check_cond(pause_ack == '1, $sformatf("pause_ack not raised within %0d cycles", waited));
        check_value("irq while paused", 'h0, irq);
        apb_read(reg_addr(1, REG_ER), d, err);
        check_value("paused read pslverr", 1, err);
        check_value("paused read prdata", 0, d);
        apb_write(reg_addr(0, REG_CR), 1 << CR_ENABLE, '1, err);
        check_value("paused write pslverr", 1, err);
        @(negedge clk);
        pause_req = 1'b0;
        waited    = 0;
        while (pause_ack != '0 && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        check_cond(pause_ack == '0, $sformatf("pause_ack not cleared within %0d cycles", waited));
        check_value("irq after resume", 'h2, irq);
        read_reg(1, REG_ER, d);
        check_value("timer 1 event kept", 1 << ER_AUTO_RELOAD, d);
        read_reg(0, REG_CR, d);
        check_value("write ignored while paused", 0, d);
        finish_test();
    endtask

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        paddr        = '0;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        pwdata       = '0;
        pstrb        = '0;
        pause_req    = 1'b0;
        lfsr_state   = LFSR_SEED;
        errors       = 0;
        total_errors = 0;
        run_tests    = 0;
        failed_tests = 0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        reset_and_strobe_test();
        error_response_test();
        counting_test();
        independence_test();
        pause_test();

        $display("%0d tests run, %0d failed, %0d check errors, %0d assertion failures",
                 run_tests, failed_tests, total_errors, dut_i.chk_i.violations);
        if (failed_tests == 0 && dut_i.chk_i.violations == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verification/timer_subsys_checker.sv */
`default_nettype none

module timer_subsys_checker (
    input logic                             clk,
    input logic                             rst,
    input logic                             psel,
    input logic                             penable,
    input logic                             pready,
    input logic                             pslverr,
    input logic                             pause_req,
    input logic [timer_pkg::NUM_TIMERS-1:0] pause_ack,
    input logic [timer_pkg::NUM_TIMERS-1:0] irq
);
    int unsigned violations = 0; // Read back by the testbench

    // Slave answers a setup cycle on the next edge
    ready_after_setup: assert property (@(posedge clk) disable iff (rst)
        (psel && !penable) |=> pready)
        else begin
            violations++;
            $error("pready not high one cycle after the setup cycle");
        end

    error_with_ready: assert property (@(posedge clk) disable iff (rst)
        pslverr |-> pready)
        else begin
            violations++;
            $error("pslverr high without pready");
        end

    // A new ack bit needs the request still present
    ack_needs_request: assert property (@(posedge clk) disable iff (rst)
        ((pause_ack & ~$past(pause_ack)) != '0) |-> pause_req)
        else begin
            violations++;
            $error("pause_ack rose while pause_req was low");
        end

    no_irq_when_paused: assert property (@(posedge clk) disable iff (rst)
        (irq & pause_ack) == '0)
        else begin
            violations++;
            $error("irq high together with its pause_ack bit");
        end

endmodule

bind timer_subsys timer_subsys_checker chk_i (
    .clk       (clk),
    .rst       (rst),
    .psel      (psel),
    .penable   (penable),
    .pready    (pready),
    .pslverr   (pslverr),
    .pause_req (pause_req),
    .pause_ack (pause_ack),
    .irq       (irq)
);

`default_nettype wire
